// File: build.f
+incdir+rtl
rtl/md_pkg.sv
rtl/phys_regfile.sv
rtl/md_rs.sv
rtl/md_unit.sv
rtl/md_cluster.sv
sim/md_props.sv
sim/md_checker.sv
sim/md_tb.sv

// File: rtl/md_cluster.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defines.svh"

module md_cluster (
    input  logic               clk,
    input  logic               rst,
    input  md_pkg::md_uop_t    dispatch_uop,
    input  logic               dispatch_valid,
    output logic               dispatch_ready,
    input  md_pkg::cdb_t       ext_cdb,
    output md_pkg::cdb_t       md_cdb
);

    // port 0 from the other units, port 1 from mul/div
    md_pkg::cdb_t           cdb_bus [`MD_CDB_PORTS];

    logic [`MD_TAG_W-1:0]   rd_addr1;
    logic [`MD_TAG_W-1:0]   rd_addr2;
    logic [`MD_XLEN-1:0]    rd_data1;
    logic [`MD_XLEN-1:0]    rd_data2;
    md_pkg::md_issue_t      issue_pkt;
    logic                   issue_valid;
    logic                   issue_ready;

    assign cdb_bus[0] = ext_cdb;
    assign cdb_bus[1] = md_cdb;

    md_rs md_rs_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_uop   (dispatch_uop),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb_bus),
        .rd_addr1       (rd_addr1),
        .rd_addr2       (rd_addr2),
        .rd_data1       (rd_data1),
        .rd_data2       (rd_data2),
        .issue_pkt      (issue_pkt),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready)
    );

    phys_regfile phys_regfile_i (
        .clk      (clk),
        .rst      (rst),
        .cdb      (cdb_bus),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    md_unit md_unit_i (
        .clk         (clk),
        .rst         (rst),
        .issue_pkt   (issue_pkt),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .md_cdb      (md_cdb)
    );

endmodule

`default_nettype wire

// File: rtl/md_defines.svh
`ifndef MD_DEFINES_SVH
`define MD_DEFINES_SVH

// reservation station entries
`define MD_RS_DEPTH 8

// physical register file size and index width
`define MD_PRF_DEPTH 32
`define MD_TAG_W 5

// datapath width
`define MD_XLEN 32

// CDB ports, 0 = other units, 1 = mul/div
`define MD_CDB_PORTS 2

`endif

// File: rtl/md_pkg.sv
`default_nettype none

`include "md_defines.svh"

package md_pkg;

    // unsigned M-extension subset handled here
    typedef enum logic [1:0] {
        MUL   = 2'd0,
        MULHU = 2'd1,
        DIVU  = 2'd2,
        REMU  = 2'd3
    } md_op_t;

    // next-value source of one station slot
    typedef enum logic [1:0] {
        SELF    = 2'd0,
        PREV    = 2'd1,
        PUSH_IN = 2'd2
    } rs_update_t;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        MUL_WAIT = 2'd1,
        DIV_RUN  = 2'd2,
        DONE     = 2'd3
    } md_state_t;

    // renamed micro-op as held in the station
    typedef struct packed {
        md_op_t                op;
        logic [`MD_TAG_W-1:0]  rd_phy;
        logic [`MD_TAG_W-1:0]  rs1_phy;
        logic                  rs1_ready;
        logic [`MD_TAG_W-1:0]  rs2_phy;
        logic                  rs2_ready;
    } md_uop_t;

    typedef struct packed {
        md_op_t                op;
        logic [`MD_TAG_W-1:0]  rd_phy;
        logic [`MD_XLEN-1:0]   rs1_value;
        logic [`MD_XLEN-1:0]   rs2_value;
    } md_issue_t;

    typedef struct packed {
        logic                  valid;
        logic [`MD_TAG_W-1:0]  tag;
        logic [`MD_XLEN-1:0]   value;
    } cdb_t;

endpackage

`default_nettype wire

// File: rtl/md_rs.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defines.svh"

module md_rs (
    input  logic                   clk,
    input  logic                   rst,
    input  md_pkg::md_uop_t        dispatch_uop,
    input  logic                   dispatch_valid,
    output logic                   dispatch_ready,
    input  md_pkg::cdb_t           cdb [`MD_CDB_PORTS],
    output logic [`MD_TAG_W-1:0]   rd_addr1,
    output logic [`MD_TAG_W-1:0]   rd_addr2,
    input  logic [`MD_XLEN-1:0]    rd_data1,
    input  logic [`MD_XLEN-1:0]    rd_data2,
    output md_pkg::md_issue_t      issue_pkt,
    output logic                   issue_valid,
    input  logic                   issue_ready
);

    localparam int DEPTH = `MD_RS_DEPTH;
    localparam int IDX_W = $clog2(`MD_RS_DEPTH);

    // slot 0 is the oldest entry
    md_pkg::md_uop_t     slots     [DEPTH];
    md_pkg::md_uop_t     woke      [DEPTH];
    md_pkg::md_uop_t     slots_nxt [DEPTH];
    md_pkg::rs_update_t  upd_sel   [DEPTH];
    md_pkg::md_uop_t     push_uop;

    logic [IDX_W:0]      count;
    logic [IDX_W:0]      count_nxt;
    logic [IDX_W:0]      push_idx;
    logic [IDX_W-1:0]    sel_idx;
    logic                sel_found;
    logic                push_en;
    logic                pop_en;

    // sources whose tag is on either CDB port this cycle become ready
    function automatic md_pkg::md_uop_t wake(input md_pkg::md_uop_t u);
        md_pkg::md_uop_t w;
        w = u;
        for (int p = 0; p < `MD_CDB_PORTS; p++) begin
            if (cdb[p].valid && cdb[p].tag == u.rs1_phy) begin
                w.rs1_ready = 1'b1;
            end
            if (cdb[p].valid && cdb[p].tag == u.rs2_phy) begin
                w.rs2_ready = 1'b1;
            end
        end
        return w;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            woke[i] = wake(slots[i]);
        end
        push_uop = wake(dispatch_uop);
    end

    // ------------------------------------------------------------
    // oldest-first select
    // ------------------------------------------------------------

    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!sel_found && (IDX_W+1)'(i) < count &&
                woke[i].rs1_ready && woke[i].rs2_ready) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    assign issue_valid = sel_found;
    assign rd_addr1    = slots[sel_idx].rs1_phy;
    assign rd_addr2    = slots[sel_idx].rs2_phy;

    always_comb begin
        issue_pkt.op        = slots[sel_idx].op;
        issue_pkt.rd_phy    = slots[sel_idx].rd_phy;
        issue_pkt.rs1_value = rd_data1;
        issue_pkt.rs2_value = rd_data2;
    end

    // ------------------------------------------------------------
    // push, pop and compress
    // ------------------------------------------------------------

    assign dispatch_ready = (count != (IDX_W+1)'(DEPTH));
    assign pop_en         = issue_valid && issue_ready;
    assign push_en        = dispatch_valid && dispatch_ready;
    // new entry goes on top of what is left after the pop
    assign push_idx       = count - (IDX_W+1)'(pop_en);
    assign count_nxt      = push_idx + (IDX_W+1)'(push_en);

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            upd_sel[i] = md_pkg::SELF;
            if (pop_en && IDX_W'(i) >= sel_idx) begin
                upd_sel[i] = md_pkg::PREV;
            end
            if (push_en && (IDX_W+1)'(i) == push_idx) begin
                upd_sel[i] = md_pkg::PUSH_IN;
            end
            case (upd_sel[i])
                // top slot wraps to slot 0, it is empty after a pop anyway
                md_pkg::PREV:    slots_nxt[i] = woke[(i + 1) % DEPTH];
                md_pkg::PUSH_IN: slots_nxt[i] = push_uop;
                default:         slots_nxt[i] = woke[i];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            slots[i] <= slots_nxt[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count_nxt;
        end
    end

endmodule

`default_nettype wire

// File: rtl/md_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defines.svh"

module md_unit (
    input  logic               clk,
    input  logic               rst,
    input  md_pkg::md_issue_t  issue_pkt,
    input  logic               issue_valid,
    output logic               issue_ready,
    output md_pkg::cdb_t       md_cdb
);

    localparam int XLEN   = `MD_XLEN;
    localparam int STEP_W = $clog2(`MD_XLEN) + 1;

    md_pkg::md_state_t       state;
    logic [STEP_W-1:0]       step;
    logic                    cdb_valid_q;

    md_pkg::md_op_t          op_q;
    logic [`MD_TAG_W-1:0]    rd_q;
    logic [XLEN-1:0]         a_q;
    logic [XLEN-1:0]         b_q;
    logic                    div_zero_q;
    // product, or remainder:quotient while dividing
    logic [2*XLEN-1:0]       acc;
    logic [`MD_TAG_W-1:0]    cdb_tag_q;
    logic [XLEN-1:0]         cdb_value_q;

    logic [XLEN:0]           rem_sh;
    logic                    quo_bit;
    logic [XLEN-1:0]         rem_nxt;
    logic [XLEN-1:0]         result;

    assign issue_ready = (state == md_pkg::IDLE);
    assign md_cdb      = '{valid: cdb_valid_q, tag: cdb_tag_q, value: cdb_value_q};

    // one restoring step
    always_comb begin
        rem_sh  = {acc[2*XLEN-1:XLEN], acc[XLEN-1]};
        quo_bit = (rem_sh >= {1'b0, b_q});
        rem_nxt = quo_bit ? XLEN'(rem_sh - {1'b0, b_q}) : rem_sh[XLEN-1:0];
    end

    always_comb begin
        case (op_q)
            md_pkg::MUL:   result = acc[XLEN-1:0];
            md_pkg::MULHU: result = acc[2*XLEN-1:XLEN];
            md_pkg::DIVU:  result = div_zero_q ? '1 : acc[XLEN-1:0];
            default:       result = div_zero_q ? a_q : acc[2*XLEN-1:XLEN];
        endcase
    end

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= md_pkg::IDLE;
            step        <= '0;
            cdb_valid_q <= 1'b0;
        end else begin
            cdb_valid_q <= 1'b0;
            case (state)
                md_pkg::IDLE: begin
                    step <= '0;
                    if (issue_valid) begin
                        if (issue_pkt.op == md_pkg::MUL || issue_pkt.op == md_pkg::MULHU) begin
                            state <= md_pkg::MUL_WAIT;
                        end else begin
                            state <= md_pkg::DIV_RUN;
                        end
                    end
                end
                md_pkg::MUL_WAIT: state <= md_pkg::DONE;
                md_pkg::DIV_RUN: begin
                    // step 0 is setup, steps 1..XLEN iterate
                    step <= step + 1'b1;
                    if (step == STEP_W'(XLEN)) begin
                        state <= md_pkg::DONE;
                    end
                end
                default: begin
                    cdb_valid_q <= 1'b1;
                    state       <= md_pkg::IDLE;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            md_pkg::IDLE: begin
                if (issue_valid) begin
                    op_q       <= issue_pkt.op;
                    rd_q       <= issue_pkt.rd_phy;
                    a_q        <= issue_pkt.rs1_value;
                    b_q        <= issue_pkt.rs2_value;
                    div_zero_q <= (issue_pkt.rs2_value == '0);
                end
            end
            md_pkg::MUL_WAIT: acc <= (2*XLEN)'(a_q) * (2*XLEN)'(b_q);
            md_pkg::DIV_RUN: begin
                if (step == '0) begin
                    acc <= {{XLEN{1'b0}}, a_q};
                end else begin
                    acc <= {rem_nxt, acc[XLEN-2:0], quo_bit};
                end
            end
            default: begin
                cdb_tag_q   <= rd_q;
                cdb_value_q <= result;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/phys_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defines.svh"

module phys_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  md_pkg::cdb_t          cdb [`MD_CDB_PORTS],
    input  logic [`MD_TAG_W-1:0]  rd_addr1,
    input  logic [`MD_TAG_W-1:0]  rd_addr2,
    output logic [`MD_XLEN-1:0]   rd_data1,
    output logic [`MD_XLEN-1:0]   rd_data2
);

    logic [`MD_XLEN-1:0] regs [`MD_PRF_DEPTH];

    // every CDB port has its own write port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MD_PRF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int p = 0; p < `MD_CDB_PORTS; p++) begin
                if (cdb[p].valid) begin
                    regs[cdb[p].tag] <= cdb[p].value;
                end
            end
        end
    end

    // bypass a same-cycle broadcast to the readers
    always_comb begin
        rd_data1 = regs[rd_addr1];
        rd_data2 = regs[rd_addr2];
        for (int p = 0; p < `MD_CDB_PORTS; p++) begin
            if (cdb[p].valid && cdb[p].tag == rd_addr1) begin
                rd_data1 = cdb[p].value;
            end
            if (cdb[p].valid && cdb[p].tag == rd_addr2) begin
                rd_data2 = cdb[p].value;
            end
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# compile and run the mul/div cluster testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f build.f --top-module md_tb -Mdir obj_dir -o md_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/md_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: sim/md_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defines.svh"

module md_checker (
    input  logic             clk,
    input  logic             rst,
    input  md_pkg::md_uop_t  dispatch_uop,
    input  logic             dispatch_valid,
    input  logic             dispatch_ready,
    input  md_pkg::cdb_t     ext_cdb,
    input  md_pkg::cdb_t     md_cdb,
    input  logic             end_of_run,
    output int               pending_count,
    output int               mismatch_errors,
    output int               other_errors
);

    localparam int XLEN = `MD_XLEN;
    localparam int REGS = `MD_PRF_DEPTH;

    logic [XLEN-1:0]        shadow    [REGS];
    // pending micro-ops indexed by rd tag
    logic                   pend      [REGS];
    md_pkg::md_op_t         pend_op   [REGS];
    logic [`MD_TAG_W-1:0]   pend_src1 [REGS];
    logic [`MD_TAG_W-1:0]   pend_src2 [REGS];
    int                     pend_seq  [REGS];
    logic                   wait1     [REGS];
    logic                   wait2     [REGS];
    int                     dispatch_seq;
    int                     bypass_count;
    int                     full_cycles;
    logic                   end_seen;

    // unsigned RISC-V M rules with division by zero
    function automatic logic [XLEN-1:0] expected_result(input md_pkg::md_op_t op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] prod;
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (op)
            md_pkg::MUL:   return prod[XLEN-1:0];
            md_pkg::MULHU: return prod[2*XLEN-1:XLEN];
            md_pkg::DIVU:  return (b == '0) ? {XLEN{1'b1}} : a / b;
            default:       return (b == '0) ? a : a % b;
        endcase
    endfunction

    function automatic logic on_bus(input logic [`MD_TAG_W-1:0] tag);
        return (ext_cdb.valid && ext_cdb.tag == tag) || (md_cdb.valid && md_cdb.tag == tag);
    endfunction

    task automatic check_result();
        logic [`MD_TAG_W-1:0] t;
        logic [XLEN-1:0]      exp;
        t = md_cdb.tag;
        if (!pend[t]) begin
            $display("error: md_cdb result for tag %h has no pending micro-op", t);
            other_errors++;
        end else if (wait1[t] || wait2[t]) begin
            $display("error: result for tag %h came before its sources were written", t);
            other_errors++;
        end else begin
            exp = expected_result(pend_op[t], shadow[pend_src1[t]], shadow[pend_src2[t]]);
            if (md_cdb.value !== exp) begin
                $display("ERROR md_cdb.value tag=%h exp=%h got=%h", t, exp, md_cdb.value);
                mismatch_errors++;
            end
        end
        if (pend[t]) begin
            // an older micro-op still pending means this one went past it
            for (int i = 0; i < REGS; i++) begin
                if (pend[i] && pend_seq[i] < pend_seq[t]) begin
                    bypass_count++;
                end
            end
            pend[t] = 1'b0;
            pending_count--;
        end
    endtask

    task automatic record_dispatch();
        logic [`MD_TAG_W-1:0] t;
        t = dispatch_uop.rd_phy;
        if (pend[t]) begin
            $display("error: dispatch to rd tag %h while that tag is still pending", t);
            other_errors++;
        end else begin
            pending_count++;
        end
        pend[t]      = 1'b1;
        pend_op[t]   = dispatch_uop.op;
        pend_src1[t] = dispatch_uop.rs1_phy;
        pend_src2[t] = dispatch_uop.rs2_phy;
        pend_seq[t]  = dispatch_seq;
        dispatch_seq++;
        wait1[t]     = !dispatch_uop.rs1_ready && !on_bus(dispatch_uop.rs1_phy);
        wait2[t]     = !dispatch_uop.rs2_ready && !on_bus(dispatch_uop.rs2_phy);
    endtask

    // sample at the falling edge where all inputs have settled
    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < REGS; i++) begin
                shadow[i] = '0;
                pend[i]   = 1'b0;
                wait1[i]  = 1'b0;
                wait2[i]  = 1'b0;
            end
            pending_count   = 0;
            mismatch_errors = 0;
            other_errors    = 0;
            dispatch_seq    = 0;
            bypass_count    = 0;
            full_cycles     = 0;
            end_seen        = 1'b0;
        end else begin
            if (md_cdb.valid) begin
                check_result();
            end
            for (int i = 0; i < REGS; i++) begin
                if (pend[i] && on_bus(pend_src1[i])) begin
                    wait1[i] = 1'b0;
                end
                if (pend[i] && on_bus(pend_src2[i])) begin
                    wait2[i] = 1'b0;
                end
            end
            if (dispatch_valid && dispatch_ready) begin
                record_dispatch();
            end
            if (ext_cdb.valid) begin
                shadow[ext_cdb.tag] = ext_cdb.value;
            end
            if (md_cdb.valid) begin
                shadow[md_cdb.tag] = md_cdb.value;
            end
            if (!dispatch_ready) begin
                full_cycles++;
            end
            if (end_of_run && !end_seen) begin
                end_seen = 1'b1;
                for (int i = 0; i < REGS; i++) begin
                    if (pend[i]) begin
                        $display("error: micro-op with rd tag %h never completed", i);
                        other_errors++;
                    end
                end
                if (full_cycles == 0) begin
                    $display("error: the station never filled up and held back dispatch");
                    other_errors++;
                end
                if (bypass_count == 0) begin
                    $display("error: no younger micro-op ever completed ahead of an older one");
                    other_errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/md_props.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defines.svh"

module md_props (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               dispatch_valid,
    input  logic                               dispatch_ready,
    input  logic                               issue_valid,
    input  logic                               issue_ready,
    input  logic [$clog2(`MD_RS_DEPTH)-1:0]    sel_idx,
    input  md_pkg::md_uop_t                    slots [`MD_RS_DEPTH],
    input  md_pkg::cdb_t                       cdb [`MD_CDB_PORTS]
);

    localparam int CNT_W = $clog2(`MD_RS_DEPTH) + 1;

    md_pkg::md_uop_t   sel_uop;
    logic              src_ok;
    logic [CNT_W-1:0]  occupied;
    int                fail_count = 0;

    function automatic logic on_cdb(input logic [`MD_TAG_W-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `MD_CDB_PORTS; p++) begin
            if (cdb[p].valid && cdb[p].tag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // selected entry has both sources ready in the slot or on a bus
    always_comb begin
        sel_uop = slots[sel_idx];
        src_ok  = (sel_uop.rs1_ready || on_cdb(sel_uop.rs1_phy)) &&
                  (sel_uop.rs2_ready || on_cdb(sel_uop.rs2_phy));
    end

    // occupancy seen from the dispatch and issue handshakes
    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= '0;
        end else begin
            occupied <= occupied + CNT_W'(dispatch_valid && dispatch_ready)
                                 - CNT_W'(issue_valid && issue_ready);
        end
    end

    // ------------------------------------------------------------
    // station and broadcast properties
    // ------------------------------------------------------------

    full_only: assert property (@(posedge clk) disable iff (rst)
        !dispatch_ready |-> occupied == CNT_W'(`MD_RS_DEPTH))
    else begin
        $error("dispatch_ready low while the station has a free slot");
        fail_count++;
    end

    issue_sources: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> src_ok)
    else begin
        $error("issue_valid with a selected entry whose sources are not ready");
        fail_count++;
    end

    // md unit broadcasts on port 1
    cdb_pulse: assert property (@(posedge clk) disable iff (rst)
        cdb[1].valid |=> !cdb[1].valid)
    else begin
        $error("md_cdb.valid high for two consecutive cycles");
        fail_count++;
    end

endmodule

bind md_rs md_props md_props_i (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .sel_idx        (sel_idx),
    .slots          (slots),
    .cdb            (cdb)
);

`default_nettype wire

// File: sim/md_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defines.svh"

module md_tb;

    typedef enum logic [1:0] {
        ROW_WRITE,
        ROW_DISPATCH,
        ROW_IDLE,
        ROW_DRAIN
    } row_kind_t;

    // value is the cycle count for ROW_IDLE
    typedef struct packed {
        row_kind_t             kind;
        logic [`MD_TAG_W-1:0]  tag;
        logic [`MD_XLEN-1:0]   value;
        md_pkg::md_uop_t       uop;
    } stim_row_t;

    logic              clk;
    logic              rst;
    md_pkg::md_uop_t   dispatch_uop;
    logic              dispatch_valid;
    logic              dispatch_ready;
    md_pkg::cdb_t      ext_cdb;
    md_pkg::cdb_t      md_cdb;

    logic              end_of_run;
    int                pending_count;
    int                mismatch_errors;
    int                other_errors;
    int                assert_errors;

    stim_row_t         stim_q [$];
    int                seed;
    int                cycle_count = 0;
    int                timeout_limit = 100000;

    md_cluster md_cluster_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_uop   (dispatch_uop),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .ext_cdb        (ext_cdb),
        .md_cdb         (md_cdb)
    );

    md_checker md_checker_i (
        .clk             (clk),
        .rst             (rst),
        .dispatch_uop    (dispatch_uop),
        .dispatch_valid  (dispatch_valid),
        .dispatch_ready  (dispatch_ready),
        .ext_cdb         (ext_cdb),
        .md_cdb          (md_cdb),
        .end_of_run      (end_of_run),
        .pending_count   (pending_count),
        .mismatch_errors (mismatch_errors),
        .other_errors    (other_errors)
    );

    assign assert_errors = md_cluster_i.md_rs_i.md_props_i.fail_count;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------

    task automatic add_write(input int tag, input logic [`MD_XLEN-1:0] value);
        stim_row_t r;
        r       = '0;
        r.kind  = ROW_WRITE;
        r.tag   = `MD_TAG_W'(tag);
        r.value = value;
        stim_q.push_back(r);
    endtask

    task automatic add_dispatch(input md_pkg::md_op_t op, input int rd,
                                input int rs1, input int rdy1, input int rs2, input int rdy2);
        stim_row_t r;
        r               = '0;
        r.kind          = ROW_DISPATCH;
        r.uop.op        = op;
        r.uop.rd_phy    = `MD_TAG_W'(rd);
        r.uop.rs1_phy   = `MD_TAG_W'(rs1);
        r.uop.rs1_ready = (rdy1 != 0);
        r.uop.rs2_phy   = `MD_TAG_W'(rs2);
        r.uop.rs2_ready = (rdy2 != 0);
        stim_q.push_back(r);
    endtask

    task automatic add_wait(input row_kind_t kind, input int cycles);
        stim_row_t r;
        r       = '0;
        r.kind  = kind;
        r.value = `MD_XLEN'(cycles);
        stim_q.push_back(r);
    endtask

    task automatic build_table();
        // source operands, random and edge values
        add_write(1, $random(seed));
        add_write(2, $random(seed));
        add_write(3, 32'hffffffff);
        add_write(4, 32'hfffffffe);
        add_write(5, 32'h00000000);
        add_write(6, 32'h00000007);
        add_write(7, 32'h12345678);
        // multiply halves
        add_dispatch(md_pkg::MUL,    8, 1, 1, 2, 1);
        add_dispatch(md_pkg::MULHU,  9, 1, 1, 2, 1);
        add_dispatch(md_pkg::MULHU, 10, 3, 1, 4, 1);
        add_dispatch(md_pkg::MUL,   11, 3, 1, 4, 1);
        // divide, by zero, small dividend
        add_dispatch(md_pkg::DIVU,  12, 7, 1, 6, 1);
        add_dispatch(md_pkg::REMU,  13, 7, 1, 6, 1);
        add_dispatch(md_pkg::DIVU,  14, 1, 1, 5, 1);
        add_dispatch(md_pkg::REMU,  15, 1, 1, 5, 1);
        add_dispatch(md_pkg::DIVU,  16, 6, 1, 7, 1);
        add_dispatch(md_pkg::REMU,  17, 6, 1, 7, 1);
        add_wait(ROW_DRAIN, 0);
        // older op waits on tag 19, younger one passes it
        add_dispatch(md_pkg::MUL,   18, 19, 0, 1, 1);
        add_dispatch(md_pkg::MUL,   20, 1, 1, 2, 1);
        add_wait(ROW_IDLE, 8);
        add_write(19, $random(seed));
        add_wait(ROW_DRAIN, 0);
        // chain through md_cdb
        add_dispatch(md_pkg::MUL,   21, 7, 1, 6, 1);
        add_dispatch(md_pkg::DIVU,  22, 21, 0, 6, 1);
        add_dispatch(md_pkg::REMU,  23, 7, 1, 22, 0);
        add_wait(ROW_DRAIN, 0);
        // long divide keeps eight consumers parked, station fills
        add_dispatch(md_pkg::DIVU,  26, 7, 1, 6, 1);
        add_dispatch(md_pkg::MUL,    8, 26, 0, 1, 1);
        add_dispatch(md_pkg::MULHU,  9, 26, 0, 3, 1);
        add_dispatch(md_pkg::DIVU,  10, 26, 0, 6, 1);
        add_dispatch(md_pkg::REMU,  11, 26, 0, 6, 1);
        add_dispatch(md_pkg::MUL,   12, 2, 1, 26, 0);
        add_dispatch(md_pkg::DIVU,  13, 3, 1, 26, 0);
        add_dispatch(md_pkg::REMU,  14, 26, 0, 26, 0);
        add_dispatch(md_pkg::MULHU, 15, 26, 0, 26, 0);
        add_dispatch(md_pkg::MUL,   16, 1, 1, 2, 1);
        add_dispatch(md_pkg::MUL,   17, 4, 1, 7, 1);
        add_wait(ROW_DRAIN, 0);
    endtask

    task automatic apply_row(input stim_row_t row);
        ext_cdb        <= '0;
        dispatch_valid <= 1'b0;
        case (row.kind)
            ROW_WRITE: begin
                ext_cdb <= '{valid: 1'b1, tag: row.tag, value: row.value};
                @(posedge clk);
            end
            ROW_DISPATCH: begin
                dispatch_uop   <= row.uop;
                dispatch_valid <= 1'b1;
                // hold the micro-op while the station is full
                @(negedge clk);
                while (!dispatch_ready) begin
                    @(negedge clk);
                end
                @(posedge clk);
            end
            ROW_IDLE: begin
                repeat (row.value) @(posedge clk);
            end
            default: begin
                @(posedge clk);
                while (pending_count != 0) begin
                    @(posedge clk);
                end
            end
        endcase
    endtask

    task automatic print_counts();
        $display("errors: mismatch=%0d other=%0d assertion=%0d",
                 mismatch_errors, other_errors, assert_errors);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        rst            = 1'b1;
        dispatch_uop   = '0;
        dispatch_valid = 1'b0;
        ext_cdb        = '0;
        end_of_run     = 1'b0;
        seed           = 32'h30200a29;
        build_table();
        timeout_limit = stim_q.size() * 40 + 200;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < stim_q.size(); r++) begin
            apply_row(stim_q[r]);
        end
        ext_cdb        <= '0;
        dispatch_valid <= 1'b0;
        while (pending_count != 0) begin
            @(posedge clk);
        end
        end_of_run <= 1'b1;
        @(negedge clk);
        @(posedge clk);
        print_counts();
        if (mismatch_errors + other_errors + assert_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run did not complete within %0d cycles", timeout_limit);
            print_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire
